// ==== eth_pkg.sv ====
/*
 * Shared widths, register map and stream types of the uDMA Ethernet core.
 * Single clock domain only. No PHY, no FCS, no MAC status bits.
 * Byte count fields use the uDMA datasize coding (bytes minus one).
 */

`default_nettype none

package eth_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int unsigned BYTE_W         = 8;
    localparam int unsigned BYTES_PER_WORD = 4;
    localparam int unsigned WORD_W         = BYTES_PER_WORD * BYTE_W;

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [WORD_W-1:0] word_t;      // udma word, also cfg data
    typedef logic [1:0]        byte_cnt_t;  // bytes in word minus one
    typedef logic [4:0]        cfg_addr_t;  // register word address
    typedef logic [15:0]       frame_cnt_t;

    //////////////////////////////////////////////////
    // register map
    //////////////////////////////////////////////////
    localparam cfg_addr_t REG_CTRL      = 5'd0;
    localparam cfg_addr_t REG_STATUS    = 5'd1;
    localparam cfg_addr_t REG_RX_FRAMES = 5'd2;

    // REG_CTRL bits
    localparam int unsigned CTRL_EN_RX_BIT     = 0;
    localparam int unsigned CTRL_EN_TX_BIT     = 1;
    localparam int unsigned CTRL_RX_IRQ_EN_BIT = 2;

    // REG_STATUS bits
    localparam int unsigned STATUS_TX_BUSY_BIT = 0;
    localparam int unsigned STATUS_RX_BUSY_BIT = 1;

    // one mac side stream beat
    typedef struct packed {
        byte_t data;
        logic  last;     // final byte of frame
    } eth_byte_s;

    // one packed udma word with its byte count
    typedef struct packed {
        word_t     data;
        byte_cnt_t size;
        logic      last;
    } eth_word_s;

    typedef enum logic {
        COLLECT,
        HOLD
    } rx_state_e;

endpackage

`default_nettype wire

// ==== eth_reg_if.sv ====
/*
 * Configuration registers behind the uDMA cfg valid/rwn/ready handshake.
 * The host holds valid, rwn, addr and data until ready. Ready lasts one
 * cycle and arrives one cycle after valid is first seen.
 * Unmapped addresses read as zero and ignore writes.
 */

`default_nettype none

module eth_reg_if (
    input  logic               sys_clk_i,
    input  logic               reset_i,
    input  logic               cfg_valid_i,
    input  logic               cfg_rwn_i,
    input  eth_pkg::cfg_addr_t cfg_addr_i,
    input  eth_pkg::word_t     cfg_data_i,
    input  logic               tx_busy_i,
    input  logic               rx_busy_i,
    input  logic               frame_done_i,
    output logic               cfg_ready_o,
    output eth_pkg::word_t     cfg_data_o,
    output logic               en_tx_o,
    output logic               en_rx_o,
    output logic               rx_irq_en_o
);

    logic                ready_q;
    eth_pkg::word_t      rdata_q;
    eth_pkg::word_t      rdata;
    logic                en_tx_q;
    logic                en_rx_q;
    logic                irq_en_q;
    eth_pkg::frame_cnt_t frames_q;

    // read mux, sampled when the request is first seen
    always_comb begin
        rdata = '0;
        case (cfg_addr_i)
            eth_pkg::REG_CTRL: begin
                rdata[eth_pkg::CTRL_EN_RX_BIT]     = en_rx_q;
                rdata[eth_pkg::CTRL_EN_TX_BIT]     = en_tx_q;
                rdata[eth_pkg::CTRL_RX_IRQ_EN_BIT] = irq_en_q;
            end
            eth_pkg::REG_STATUS: begin
                rdata[eth_pkg::STATUS_TX_BUSY_BIT] = tx_busy_i;
                rdata[eth_pkg::STATUS_RX_BUSY_BIT] = rx_busy_i;
            end
            eth_pkg::REG_RX_FRAMES: rdata = eth_pkg::word_t'(frames_q);
            default: rdata = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////
    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            ready_q <= 1'b0;
            rdata_q <= '0;
        end else begin
            ready_q <= cfg_valid_i && !ready_q;  // never two in a row
            rdata_q <= (cfg_valid_i && !ready_q && cfg_rwn_i) ? rdata : '0;
        end
    end

    // ctrl bits and frame counter
    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            en_tx_q  <= 1'b0;
            en_rx_q  <= 1'b0;
            irq_en_q <= 1'b0;
            frames_q <= '0;
        end else begin
            // write lands on the edge closing the ready cycle
            if (ready_q && cfg_valid_i && !cfg_rwn_i && cfg_addr_i == eth_pkg::REG_CTRL) begin
                en_rx_q  <= cfg_data_i[eth_pkg::CTRL_EN_RX_BIT];
                en_tx_q  <= cfg_data_i[eth_pkg::CTRL_EN_TX_BIT];
                irq_en_q <= cfg_data_i[eth_pkg::CTRL_RX_IRQ_EN_BIT];
            end
            if (frame_done_i)
                frames_q <= frames_q + 1'b1;  // wraps
        end
    end

    assign cfg_ready_o = ready_q;
    assign cfg_data_o  = rdata_q;
    assign en_tx_o     = en_tx_q;
    assign en_rx_o     = en_rx_q;
    assign rx_irq_en_o = irq_en_q;

endmodule

`default_nettype wire

// ==== eth_tx_serializer.sv ====
/*
 * Splits uDMA transmit words into a byte stream, least significant first.
 * Holds one word at a time, so the next word waits for the last byte.
 * A word carries size+1 bytes. last marks the final byte of a last word.
 */

`default_nettype none

module eth_tx_serializer (
    input  logic                sys_clk_i,
    input  logic                reset_i,
    input  logic                en_tx_i,
    input  eth_pkg::word_t      data_tx_i,
    input  eth_pkg::byte_cnt_t  data_tx_size_i,
    input  logic                data_tx_last_i,
    input  logic                data_tx_valid_i,
    input  logic                mac_tx_ready_i,
    output logic                data_tx_ready_o,
    output eth_pkg::eth_byte_s  mac_tx_o,
    output logic                mac_tx_valid_o,
    output logic                busy_o
);

    logic               full_q;     // a word is in flight
    eth_pkg::word_t     shift_q;    // payload, current byte in lane 0
    eth_pkg::byte_cnt_t remain_q;   // bytes after the current one
    logic               last_q;
    logic               word_take;
    logic               byte_take;

    assign word_take = data_tx_valid_i && data_tx_ready_o;
    assign byte_take = mac_tx_valid_o && mac_tx_ready_i;

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////
    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            full_q <= 1'b0;
        end else if (word_take) begin
            full_q <= 1'b1;
        end else if (byte_take && remain_q == '0) begin
            full_q <= 1'b0;  // final byte gone
        end
    end

    // payload path
    always_ff @(posedge sys_clk_i) begin
        if (word_take) begin
            shift_q  <= data_tx_i;
            remain_q <= data_tx_size_i;
            last_q   <= data_tx_last_i;
        end else if (byte_take) begin
            shift_q  <= shift_q >> eth_pkg::BYTE_W;
            remain_q <= remain_q - 1'b1;
        end
    end

    assign data_tx_ready_o = en_tx_i && !full_q;
    assign mac_tx_valid_o  = full_q;
    assign mac_tx_o.data   = shift_q[eth_pkg::BYTE_W-1:0];
    assign mac_tx_o.last   = last_q && (remain_q == '0);  // only on final byte
    assign busy_o          = full_q;

endmodule

`default_nettype wire

// ==== eth_rx_packer.sv ====
/*
 * Packs a received byte stream into uDMA words, least significant lane first.
 * A word is emitted after four bytes or after a byte marked last.
 * Unused upper lanes are zero. No new bytes are taken while a word waits.
 * eth_rx_event_o follows the frame handover by one cycle.
 */

`default_nettype none

module eth_rx_packer (
    input  logic                sys_clk_i,
    input  logic                reset_i,
    input  logic                en_rx_i,
    input  logic                rx_irq_en_i,
    input  eth_pkg::eth_byte_s  mac_rx_i,
    input  logic                mac_rx_valid_i,
    input  logic                data_rx_ready_i,
    output logic                mac_rx_ready_o,
    output eth_pkg::word_t      data_rx_o,
    output eth_pkg::byte_cnt_t  data_rx_size_o,
    output logic                data_rx_valid_o,
    output logic                busy_o,
    output logic                frame_done_o,
    output logic                eth_rx_event_o
);

    eth_pkg::rx_state_e state_q;
    eth_pkg::byte_cnt_t lane_q;     // next free lane
    eth_pkg::eth_word_s hold_q;     // word being built or held
    eth_pkg::word_t     word_nxt;
    logic               byte_take;
    logic               handover;
    logic               word_full;
    logic               event_q;

    assign byte_take = mac_rx_valid_i && mac_rx_ready_o;
    assign handover  = data_rx_valid_o && data_rx_ready_i;
    assign word_full = (lane_q == eth_pkg::byte_cnt_t'(eth_pkg::BYTES_PER_WORD - 1));

    // drop the byte into its lane and clear the old word on lane 0
    always_comb begin
        word_nxt = (lane_q == '0) ? '0 : hold_q.data;
        word_nxt[lane_q*eth_pkg::BYTE_W +: eth_pkg::BYTE_W] = mac_rx_i.data;
    end

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////
    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            state_q <= eth_pkg::COLLECT;
            lane_q  <= '0;
        end else begin
            case (state_q)
                eth_pkg::COLLECT: begin
                    if (byte_take) begin
                        if (word_full || mac_rx_i.last) begin
                            state_q <= eth_pkg::HOLD;
                            lane_q  <= '0;
                        end else begin
                            lane_q <= lane_q + 1'b1;
                        end
                    end
                end
                eth_pkg::HOLD: if (handover) state_q <= eth_pkg::COLLECT;
                default: state_q <= eth_pkg::COLLECT;
            endcase
        end
    end

    // word register, loaded one lane per accepted byte
    always_ff @(posedge sys_clk_i) begin
        if (byte_take) begin
            hold_q.data <= word_nxt;
            hold_q.size <= lane_q;   // lane index equals bytes minus one
            hold_q.last <= mac_rx_i.last;
        end
    end

    // interrupt one cycle behind the handover
    always_ff @(posedge sys_clk_i) begin
        if (reset_i) event_q <= 1'b0;
        else         event_q <= frame_done_o && rx_irq_en_i;
    end

    assign mac_rx_ready_o  = en_rx_i && (state_q == eth_pkg::COLLECT);
    assign data_rx_valid_o = (state_q == eth_pkg::HOLD);
    assign data_rx_o       = hold_q.data;
    assign data_rx_size_o  = hold_q.size;
    assign frame_done_o    = handover && hold_q.last;
    assign busy_o          = (state_q == eth_pkg::HOLD) || (lane_q != '0);
    assign eth_rx_event_o  = event_q;

endmodule

`default_nettype wire

// ==== udma_ethernet.sv ====
/*
 * uDMA Ethernet core, system clock domain only.
 * The MAC side byte streams are plain ports. No PHY is attached here.
 */

`default_nettype none

module udma_ethernet (
    input  logic               sys_clk_i,
    input  logic               reset_i,
    // config port
    input  logic               cfg_valid_i,
    input  logic               cfg_rwn_i,
    input  eth_pkg::cfg_addr_t cfg_addr_i,
    input  eth_pkg::word_t     cfg_data_i,
    output logic               cfg_ready_o,
    output eth_pkg::word_t     cfg_data_o,
    // udma tx channel
    input  eth_pkg::word_t     data_tx_i,
    input  eth_pkg::byte_cnt_t data_tx_size_i,
    input  logic               data_tx_last_i,
    input  logic               data_tx_valid_i,
    output logic               data_tx_ready_o,
    // mac side streams
    output eth_pkg::eth_byte_s mac_tx_o,
    output logic               mac_tx_valid_o,
    input  logic               mac_tx_ready_i,
    input  eth_pkg::eth_byte_s mac_rx_i,
    input  logic               mac_rx_valid_i,
    output logic               mac_rx_ready_o,
    // udma rx channel
    output eth_pkg::word_t     data_rx_o,
    output eth_pkg::byte_cnt_t data_rx_size_o,
    output logic               data_rx_valid_o,
    input  logic               data_rx_ready_i,
    output logic               eth_rx_event_o
);

    logic s_en_tx;
    logic s_en_rx;
    logic s_rx_irq_en;
    logic s_tx_busy;
    logic s_rx_busy;
    logic s_frame_done;

    eth_reg_if u_reg_if (
        .sys_clk_i   ( sys_clk_i    ),
        .reset_i     ( reset_i      ),
        .cfg_valid_i ( cfg_valid_i  ),
        .cfg_rwn_i   ( cfg_rwn_i    ),
        .cfg_addr_i  ( cfg_addr_i   ),
        .cfg_data_i  ( cfg_data_i   ),
        .tx_busy_i   ( s_tx_busy    ),
        .rx_busy_i   ( s_rx_busy    ),
        .frame_done_i( s_frame_done ),
        .cfg_ready_o ( cfg_ready_o  ),
        .cfg_data_o  ( cfg_data_o   ),
        .en_tx_o     ( s_en_tx      ),
        .en_rx_o     ( s_en_rx      ),
        .rx_irq_en_o ( s_rx_irq_en  )
    );

    //////////////////////////////////////////////////
    // transmit path
    //////////////////////////////////////////////////
    eth_tx_serializer u_tx_ser (
        .sys_clk_i      ( sys_clk_i       ),
        .reset_i        ( reset_i         ),
        .en_tx_i        ( s_en_tx         ),
        .data_tx_i      ( data_tx_i       ),
        .data_tx_size_i ( data_tx_size_i  ),
        .data_tx_last_i ( data_tx_last_i  ),
        .data_tx_valid_i( data_tx_valid_i ),
        .mac_tx_ready_i ( mac_tx_ready_i  ),
        .data_tx_ready_o( data_tx_ready_o ),
        .mac_tx_o       ( mac_tx_o        ),
        .mac_tx_valid_o ( mac_tx_valid_o  ),
        .busy_o         ( s_tx_busy       )
    );

    //////////////////////////////////////////////////
    // receive path
    //////////////////////////////////////////////////
    eth_rx_packer u_rx_pack (
        .sys_clk_i      ( sys_clk_i       ),
        .reset_i        ( reset_i         ),
        .en_rx_i        ( s_en_rx         ),
        .rx_irq_en_i    ( s_rx_irq_en     ),
        .mac_rx_i       ( mac_rx_i        ),
        .mac_rx_valid_i ( mac_rx_valid_i  ),
        .data_rx_ready_i( data_rx_ready_i ),
        .mac_rx_ready_o ( mac_rx_ready_o  ),
        .data_rx_o      ( data_rx_o       ),
        .data_rx_size_o ( data_rx_size_o  ),
        .data_rx_valid_o( data_rx_valid_o ),
        .busy_o         ( s_rx_busy       ),
        .frame_done_o   ( s_frame_done    ),
        .eth_rx_event_o ( eth_rx_event_o  )  // irq to soc event unit
    );

endmodule

`default_nettype wire

// ==== tb_udma_ethernet_sva.sv ====
/*
 * Concurrent checks bound into udma_ethernet.
 * Cover the cfg ready pulse, stream hold under back-pressure and reset state.
 */

`default_nettype none

module tb_udma_ethernet_sva (
    input logic               sys_clk_i,
    input logic               reset_i,
    input logic               cfg_ready_o,
    input logic               data_tx_ready_o,
    input eth_pkg::eth_byte_s mac_tx_o,
    input logic               mac_tx_valid_o,
    input logic               mac_tx_ready_i,
    input logic               mac_rx_ready_o,
    input eth_pkg::word_t     data_rx_o,
    input eth_pkg::byte_cnt_t data_rx_size_o,
    input logic               data_rx_valid_o,
    input logic               data_rx_ready_i,
    input logic               eth_rx_event_o
);

    a_cfg_ready_pulse: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        cfg_ready_o |=> !cfg_ready_o)
        else $error("cfg_ready_o high on two cycles in a row");

    //////////////////////////////////////////////////
    // streams hold while stalled
    //////////////////////////////////////////////////
    a_tx_hold: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        (mac_tx_valid_o && !mac_tx_ready_i) |=> (mac_tx_valid_o && $stable(mac_tx_o)))
        else $error("mac_tx_o changed while stalled");

    a_rx_hold: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        (data_rx_valid_o && !data_rx_ready_i) |=>
            (data_rx_valid_o && $stable(data_rx_o) && $stable(data_rx_size_o)))
        else $error("data_rx_o changed while stalled");

    a_reset_state: assert property (@(posedge sys_clk_i)
        reset_i |=> !(cfg_ready_o || data_tx_ready_o || mac_tx_valid_o ||
                      mac_rx_ready_o || data_rx_valid_o || eth_rx_event_o))
        else $error("control output high after reset");

endmodule

bind udma_ethernet tb_udma_ethernet_sva sva_i (
    .sys_clk_i       ( sys_clk_i       ),
    .reset_i         ( reset_i         ),
    .cfg_ready_o     ( cfg_ready_o     ),
    .data_tx_ready_o ( data_tx_ready_o ),
    .mac_tx_o        ( mac_tx_o        ),
    .mac_tx_valid_o  ( mac_tx_valid_o  ),
    .mac_tx_ready_i  ( mac_tx_ready_i  ),
    .mac_rx_ready_o  ( mac_rx_ready_o  ),
    .data_rx_o       ( data_rx_o       ),
    .data_rx_size_o  ( data_rx_size_o  ),
    .data_rx_valid_o ( data_rx_valid_o ),
    .data_rx_ready_i ( data_rx_ready_i ),
    .eth_rx_event_o  ( eth_rx_event_o  )
);

`default_nettype wire

// ==== tb_udma_ethernet.sv ====
/*
 * Table driven testbench for the uDMA Ethernet core.
 * Inputs change on the falling clock edge and outputs are sampled there too.
 * Frame bytes and sink throttling come from $random with a fixed seed.
 */

`default_nettype none

module tb_udma_ethernet;

    typedef enum logic [1:0] {K_WR, K_RD, K_TX, K_RX} kind_e;

    typedef struct packed {
        kind_e              kind;
        eth_pkg::cfg_addr_t arg;   // register address or frame length
        eth_pkg::word_t     data;
        eth_pkg::word_t     exp;   // expected cfg data or enable flag in bit 0
    } row_s;

    localparam int N_ROWS  = 26;
    localparam int TIMEOUT = 200;

    logic               sys_clk_i;
    logic               reset_i;
    logic               cfg_valid_i;
    logic               cfg_rwn_i;
    eth_pkg::cfg_addr_t cfg_addr_i;
    eth_pkg::word_t     cfg_data_i;
    logic               cfg_ready_o;
    eth_pkg::word_t     cfg_data_o;
    eth_pkg::word_t     data_tx_i;
    eth_pkg::byte_cnt_t data_tx_size_i;
    logic               data_tx_last_i;
    logic               data_tx_valid_i;
    logic               data_tx_ready_o;
    eth_pkg::eth_byte_s mac_tx_o;
    logic               mac_tx_valid_o;
    logic               mac_tx_ready_i;
    eth_pkg::eth_byte_s mac_rx_i;
    logic               mac_rx_valid_i;
    logic               mac_rx_ready_o;
    eth_pkg::word_t     data_rx_o;
    eth_pkg::byte_cnt_t data_rx_size_o;
    logic               data_rx_valid_o;
    logic               data_rx_ready_i;
    logic               eth_rx_event_o;

    integer seed           = 97;
    int     value_errors   = 0;
    int     timeout_errors = 0;
    row_s   rows [N_ROWS];

    udma_ethernet udma_ethernet_i (.*);

    initial begin
        sys_clk_i = 1'b0;
        forever #10 sys_clk_i = ~sys_clk_i;
    end

    // one cfg transfer with valid held through the ready cycle so a write lands
    task automatic cfg_access(input logic rwn, input eth_pkg::cfg_addr_t addr,
                              input eth_pkg::word_t wdata, output eth_pkg::word_t rdata);
        int cnt;
        cnt = 0;
        @(negedge sys_clk_i);
        cfg_valid_i = 1'b1;
        cfg_rwn_i   = rwn;
        cfg_addr_i  = addr;
        cfg_data_i  = wdata;
        while (!cfg_ready_o && cnt < TIMEOUT) begin
            @(negedge sys_clk_i);
            cnt++;
        end
        if (!cfg_ready_o) begin
            $display("cfg access to address %0d never got ready", addr);
            timeout_errors++;
        end else if (cnt != 1) begin
            $display("FAILED at %0t: cfg ready came %0d cycles after valid, expected 1",
                     $time, cnt);
            value_errors++;
        end
        rdata = cfg_data_o;
        @(negedge sys_clk_i);
        cfg_valid_i = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // transmit frame of random size words
    //////////////////////////////////////////////////
    task automatic transmit_frame(input int len, input logic enabled);
        eth_pkg::eth_word_s words[$];
        eth_pkg::eth_byte_s exp_bytes[$];
        eth_pkg::eth_word_s w;
        eth_pkg::eth_byte_s b;
        logic [31:0]        r;
        int                 rem;
        int                 n;
        int                 widx;
        int                 bidx;
        int                 cnt;
        rem = len;
        while (rem > 0) begin
            w.data = $random(seed);              // unused upper lanes keep junk
            r = $random(seed);
            n = int'(r[1:0]) + 1;
            if (n > rem)
                n = rem;
            w.size = eth_pkg::byte_cnt_t'(n - 1);
            w.last = (rem == n);
            for (int k = 0; k < n; k++) begin
                b.data = w.data[k*8 +: 8];       // lsb first
                b.last = w.last && (k == n - 1);
                exp_bytes.push_back(b);
            end
            words.push_back(w);
            rem -= n;
        end
        widx = 0;
        bidx = 0;
        cnt  = 0;
        if (!enabled) begin
            @(negedge sys_clk_i);
            data_tx_i       = words[0].data;
            data_tx_valid_i = 1'b1;
            repeat (8) begin
                @(negedge sys_clk_i);
                if (data_tx_ready_o || mac_tx_valid_o) begin
                    $display("FAILED at %0t: transmit active while disabled", $time);
                    value_errors++;
                end
            end
        end else begin
            while (bidx < exp_bytes.size() && cnt < TIMEOUT) begin
                @(negedge sys_clk_i);
                cnt++;
                r = $random(seed);
                mac_tx_ready_i  = r[0] | r[1];   // ready about 3 of 4 cycles
                data_tx_valid_i = (widx < words.size());
                if (widx < words.size()) begin
                    data_tx_i      = words[widx].data;
                    data_tx_size_i = words[widx].size;
                    data_tx_last_i = words[widx].last;
                end
                if (data_tx_valid_i && data_tx_ready_o)
                    widx++;
                if (mac_tx_valid_o && mac_tx_ready_i) begin
                    if (mac_tx_o !== exp_bytes[bidx]) begin
                        $display("FAILED at %0t: tx byte %0d is %h last %b, expected %h last %b",
                                 $time, bidx, mac_tx_o.data, mac_tx_o.last,
                                 exp_bytes[bidx].data, exp_bytes[bidx].last);
                        value_errors++;
                    end
                    bidx++;
                end
            end
            if (bidx < exp_bytes.size()) begin
                $display("transmit frame of %0d bytes did not finish in time", len);
                timeout_errors++;
            end
            @(negedge sys_clk_i);
        end
        data_tx_valid_i = 1'b0;
        mac_tx_ready_i  = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // receive frame into packed words and event
    //////////////////////////////////////////////////
    task automatic receive_frame(input int len, input logic irq_exp);
        eth_pkg::byte_t     bytes[$];
        eth_pkg::eth_word_s words[$];
        eth_pkg::eth_word_s w;
        logic [31:0]        r;
        int                 sent;
        int                 got;
        int                 events;
        int                 cnt;
        w = '0;
        for (int k = 0; k < len; k++) begin
            r = $random(seed);
            bytes.push_back(r[7:0]);
            w.data[(k % 4) * 8 +: 8] = r[7:0];
            w.size = eth_pkg::byte_cnt_t'(k % 4);
            w.last = (k == len - 1);
            if (k % 4 == 3 || w.last) begin  // word closes on 4th byte or frame end
                words.push_back(w);
                w = '0;
            end
        end
        sent   = 0;
        got    = 0;
        events = 0;
        cnt    = 0;
        while (got < words.size() && cnt < TIMEOUT) begin
            @(negedge sys_clk_i);
            cnt++;
            if (eth_rx_event_o)
                events++;
            r = $random(seed);
            data_rx_ready_i = r[0] | r[1];
            mac_rx_valid_i  = (sent < len);
            mac_rx_i.data   = (sent < len) ? bytes[sent] : '0;
            mac_rx_i.last   = (sent == len - 1);
            if (mac_rx_valid_i && mac_rx_ready_o)
                sent++;
            if (data_rx_valid_o && data_rx_ready_i) begin
                if (data_rx_o !== words[got].data || data_rx_size_o !== words[got].size) begin
                    $display("FAILED at %0t: rx word %0d is %h size %0d, expected %h size %0d",
                             $time, got, data_rx_o, data_rx_size_o,
                             words[got].data, words[got].size);
                    value_errors++;
                end
                got++;
            end
        end
        if (got < words.size()) begin
            $display("receive frame of %0d bytes was not delivered in time", len);
            timeout_errors++;
        end
        @(negedge sys_clk_i);                    // event lags the handover by one cycle
        if (eth_rx_event_o)
            events++;
        mac_rx_valid_i  = 1'b0;
        data_rx_ready_i = 1'b0;
        if (events != int'(irq_exp)) begin
            $display("FAILED at %0t: %0d rx events for a %0d byte frame, expected %0d",
                     $time, events, len, irq_exp);
            value_errors++;
        end
    endtask

    initial begin
        eth_pkg::word_t rdata;
        reset_i         = 1'b1;
        cfg_valid_i     = 1'b0;
        cfg_rwn_i       = 1'b0;
        cfg_addr_i      = '0;
        cfg_data_i      = '0;
        data_tx_i       = '0;
        data_tx_size_i  = '0;
        data_tx_last_i  = 1'b0;
        data_tx_valid_i = 1'b0;
        mac_tx_ready_i  = 1'b0;
        mac_rx_i        = '0;
        mac_rx_valid_i  = 1'b0;
        data_rx_ready_i = 1'b0;
        rows = '{
            '{K_RD, eth_pkg::REG_CTRL,      32'h0,         32'h0},
            '{K_RD, eth_pkg::REG_STATUS,    32'h0,         32'h0},
            '{K_RD, eth_pkg::REG_RX_FRAMES, 32'h0,         32'h0},
            '{K_WR, eth_pkg::REG_CTRL,      32'hFFFF_FFFD, 32'h0},  // rx and irq without tx
            '{K_RD, eth_pkg::REG_CTRL,      32'h0,         32'h5},
            '{K_RD, 5'd7,                   32'h0,         32'h0},  // unmapped
            '{K_TX, 5'd6,                   32'h0,         32'h0},  // must stay blocked
            '{K_WR, eth_pkg::REG_CTRL,      32'h7,         32'h0},
            '{K_TX, 5'd1,                   32'h0,         32'h1},
            '{K_TX, 5'd7,                   32'h0,         32'h1},
            '{K_TX, 5'd13,                  32'h0,         32'h1},
            '{K_RD, eth_pkg::REG_STATUS,    32'h0,         32'h0},
            '{K_RX, 5'd1,                   32'h0,         32'h1},
            '{K_RX, 5'd2,                   32'h0,         32'h1},
            '{K_RX, 5'd3,                   32'h0,         32'h1},
            '{K_RX, 5'd4,                   32'h0,         32'h1},
            '{K_RX, 5'd5,                   32'h0,         32'h1},
            '{K_RX, 5'd6,                   32'h0,         32'h1},
            '{K_RX, 5'd7,                   32'h0,         32'h1},
            '{K_RX, 5'd8,                   32'h0,         32'h1},
            '{K_RX, 5'd9,                   32'h0,         32'h1},
            '{K_WR, eth_pkg::REG_CTRL,      32'h3,         32'h0},  // irq off
            '{K_RX, 5'd5,                   32'h0,         32'h0},
            '{K_RX, 5'd8,                   32'h0,         32'h0},
            '{K_RD, eth_pkg::REG_RX_FRAMES, 32'h0,         32'd11},
            '{K_RD, eth_pkg::REG_STATUS,    32'h0,         32'h0}
        };
        repeat (2) @(posedge sys_clk_i);
        @(negedge sys_clk_i);
        reset_i = 1'b0;
        for (int i = 0; i < N_ROWS; i++) begin
            case (rows[i].kind)
                K_WR: begin
                    cfg_access(1'b0, rows[i].arg, rows[i].data, rdata);
                    if (rdata !== rows[i].exp) begin
                        $display("FAILED at %0t: write to address %0d returned %h, expected %h",
                                 $time, rows[i].arg, rdata, rows[i].exp);
                        value_errors++;
                    end
                end
                K_RD: begin
                    cfg_access(1'b1, rows[i].arg, '0, rdata);
                    if (rdata !== rows[i].exp) begin
                        $display("FAILED at %0t: read of address %0d gave %h, expected %h",
                                 $time, rows[i].arg, rdata, rows[i].exp);
                        value_errors++;
                    end
                end
                K_TX: transmit_frame(int'(rows[i].arg), rows[i].exp[0]);
                default: receive_frame(int'(rows[i].arg), rows[i].exp[0]);
            endcase
        end
        $display("errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
eth_pkg.sv
eth_reg_if.sv
eth_tx_serializer.sv
eth_rx_packer.sv
udma_ethernet.sv
tb_udma_ethernet_sva.sv
tb_udma_ethernet.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the uDMA Ethernet testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 -f vlog.f \
        --top-module tb_udma_ethernet --Mdir obj_dir -o sim_tb; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
